// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_helios_core \
    --Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// File: source/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                   dp_valid_i,
    input  core_pkg::alu_op_t      dp_op_i,
    input  core_pkg::src_a_sel_t   dp_src_a_i,
    input  core_pkg::src_b_sel_t   dp_src_b_i,
    input  core_pkg::data_t        dp_op1_i,
    input  core_pkg::data_t        dp_op2_i,
    input  core_pkg::addr_t        dp_pc_i,
    input  core_pkg::data_t        dp_imm_i,
    input  core_pkg::rrf_tag_t     dp_tag_i,
    output logic                   res_valid_o,
    output core_pkg::rrf_tag_t     res_tag_o,
    output core_pkg::data_t        res_data_o
);

    core_pkg::data_t op_a;
    core_pkg::data_t op_b;
    logic [4:0]      shamt;

    always_comb begin
        case (dp_src_a_i)
            core_pkg::SRC_A_PC:   op_a = dp_pc_i;
            core_pkg::SRC_A_ZERO: op_a = '0;
            default:              op_a = dp_op1_i;
        endcase
        op_b  = (dp_src_b_i == core_pkg::SRC_B_IMM) ? dp_imm_i : dp_op2_i;
        shamt = op_b[4:0];
        case (dp_op_i)
            core_pkg::ALU_SUB:  res_data_o = op_a - op_b;
            core_pkg::ALU_SLL:  res_data_o = op_a << shamt;
            core_pkg::ALU_SLT:  res_data_o = core_pkg::data_t'($signed(op_a) < $signed(op_b));
            core_pkg::ALU_SLTU: res_data_o = core_pkg::data_t'(op_a < op_b);
            core_pkg::ALU_XOR:  res_data_o = op_a ^ op_b;
            core_pkg::ALU_SRL:  res_data_o = op_a >> shamt;
            core_pkg::ALU_SRA:  res_data_o = $signed(op_a) >>> shamt;
            core_pkg::ALU_OR:   res_data_o = op_a | op_b;
            core_pkg::ALU_AND:  res_data_o = op_a & op_b;
            default:            res_data_o = op_a + op_b;
        endcase
    end

    // single cycle, the tag rides along
    assign res_valid_o = dp_valid_i;
    assign res_tag_o   = dp_tag_i;

endmodule

// File: source/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath widths
`define ADDR_LEN 32
`define DATA_LEN 32
`define INSN_LEN 32

// architectural registers
`define REG_NUM 32
`define REG_SEL 5

// rename registers, also the ROB depth
`define RRF_NUM 8
`define RRF_SEL 3

`define ENTRY_POINT 32'h0000_0000

// RV32I major opcodes
`define OP_IMM   7'b0010011
`define OP_REG   7'b0110011
`define OP_LUI   7'b0110111
`define OP_AUIPC 7'b0010111

`endif

// File: source/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

    typedef logic [`ADDR_LEN-1:0] addr_t;
    typedef logic [`DATA_LEN-1:0] data_t;
    typedef logic [`INSN_LEN-1:0] insn_t;
    typedef logic [`REG_SEL-1:0]  reg_sel_t;
    typedef logic [`RRF_SEL-1:0]  rrf_tag_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_ZERO} src_a_sel_t;

    typedef enum logic {SRC_B_REG, SRC_B_IMM} src_b_sel_t;

endpackage

// File: source/decode_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module decode_unit (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   fetch_valid_i,
    input  core_pkg::addr_t        fetch_pc_i,
    input  core_pkg::insn_t        insn_i,
    output logic                   dec_valid_o,
    output core_pkg::addr_t        dec_pc_o,
    output core_pkg::alu_op_t      dec_op_o,
    output core_pkg::src_a_sel_t   dec_src_a_o,
    output core_pkg::src_b_sel_t   dec_src_b_o,
    output core_pkg::reg_sel_t     dec_rs1_o,
    output core_pkg::reg_sel_t     dec_rs2_o,
    output core_pkg::reg_sel_t     dec_rd_o,
    output logic                   dec_wr_reg_o,
    output core_pkg::data_t        dec_imm_o
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic                 legal;
    core_pkg::alu_op_t    op;
    core_pkg::src_a_sel_t src_a;
    core_pkg::src_b_sel_t src_b;
    core_pkg::data_t      imm;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    always_comb begin
        legal = 1'b0;
        src_a = core_pkg::SRC_A_REG;
        src_b = core_pkg::SRC_B_IMM;
        imm   = {{20{insn_i[31]}}, insn_i[31:20]};
        // funct3 picks the op for both integer formats
        case (funct3)
            3'b000: op = core_pkg::ALU_ADD;
            3'b001: op = core_pkg::ALU_SLL;
            3'b010: op = core_pkg::ALU_SLT;
            3'b011: op = core_pkg::ALU_SLTU;
            3'b100: op = core_pkg::ALU_XOR;
            3'b101: op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110: op = core_pkg::ALU_OR;
            default: op = core_pkg::ALU_AND;
        endcase
        case (opcode)
            `OP_IMM: begin
                if (funct3 == 3'b001)
                    legal = (funct7 == 7'b0000000);
                else if (funct3 == 3'b101)
                    legal = ({funct7[6], funct7[4:0]} == 6'b0);
                else
                    legal = 1'b1;
            end
            `OP_REG: begin
                src_b = core_pkg::SRC_B_REG;
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
                if (funct3 == 3'b000 && funct7[5])
                    op = core_pkg::ALU_SUB;
            end
            `OP_LUI, `OP_AUIPC: begin
                legal = 1'b1;
                op    = core_pkg::ALU_ADD;
                src_a = (opcode == `OP_LUI) ? core_pkg::SRC_A_ZERO : core_pkg::SRC_A_PC;
                imm   = {insn_i[31:12], 12'h000};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            dec_valid_o <= 1'b0;
        else
            dec_valid_o <= fetch_valid_i && legal;
    end

    always_ff @(posedge clk_i) begin
        dec_pc_o     <= fetch_pc_i;
        dec_op_o     <= op;
        dec_src_a_o  <= src_a;
        dec_src_b_o  <= src_b;
        dec_rs1_o    <= insn_i[19:15];
        dec_rs2_o    <= insn_i[24:20];
        dec_rd_o     <= insn_i[11:7];
        dec_wr_reg_o <= (insn_i[11:7] != 5'd0);
        dec_imm_o    <= imm;
    end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module fetch_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    output core_pkg::addr_t   iaddr_o,
    output logic              fetch_valid_o,
    output core_pkg::addr_t   fetch_pc_o
);

    core_pkg::addr_t pc;

    assign iaddr_o = pc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc            <= `ENTRY_POINT;
            fetch_valid_o <= 1'b0;
        end else begin
            pc            <= pc + 32'd4;
            fetch_valid_o <= 1'b1;
        end
    end

    // word for this address comes back next cycle
    always_ff @(posedge clk_i) begin
        fetch_pc_o <= pc;
    end

endmodule

// File: source/helios_core.sv
`timescale 1ns/1ps

module helios_core (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  core_pkg::insn_t      idata_i,
    output core_pkg::addr_t      iaddr_o,
    output logic                 commit_we_o,
    output core_pkg::reg_sel_t   commit_rd_o,
    output core_pkg::data_t      commit_data_o
);

    logic                 fetch_valid;
    core_pkg::addr_t      fetch_pc;

    logic                 dec_valid;
    core_pkg::addr_t      dec_pc;
    core_pkg::alu_op_t    dec_op;
    core_pkg::src_a_sel_t dec_src_a;
    core_pkg::src_b_sel_t dec_src_b;
    core_pkg::reg_sel_t   dec_rs1;
    core_pkg::reg_sel_t   dec_rs2;
    core_pkg::reg_sel_t   dec_rd;
    logic                 dec_wr_reg;
    core_pkg::data_t      dec_imm;

    logic                 dp_valid;
    core_pkg::alu_op_t    dp_op;
    core_pkg::src_a_sel_t dp_src_a;
    core_pkg::src_b_sel_t dp_src_b;
    core_pkg::data_t      dp_op1;
    core_pkg::data_t      dp_op2;
    core_pkg::addr_t      dp_pc;
    core_pkg::data_t      dp_imm;
    core_pkg::rrf_tag_t   dp_tag;
    core_pkg::reg_sel_t   dp_rd;
    logic                 dp_wr_reg;

    logic                 res_valid;
    core_pkg::rrf_tag_t   res_tag;
    core_pkg::data_t      res_data;

    core_pkg::rrf_tag_t   commit_tag;

    fetch_unit u_fetch_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .iaddr_o       (iaddr_o),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc)
    );

    decode_unit u_decode_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid),
        .fetch_pc_i    (fetch_pc),
        .insn_i        (idata_i),
        .dec_valid_o   (dec_valid),
        .dec_pc_o      (dec_pc),
        .dec_op_o      (dec_op),
        .dec_src_a_o   (dec_src_a),
        .dec_src_b_o   (dec_src_b),
        .dec_rs1_o     (dec_rs1),
        .dec_rs2_o     (dec_rs2),
        .dec_rd_o      (dec_rd),
        .dec_wr_reg_o  (dec_wr_reg),
        .dec_imm_o     (dec_imm)
    );

    rename_unit u_rename_unit (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dec_valid_i   (dec_valid),
        .dec_pc_i      (dec_pc),
        .dec_op_i      (dec_op),
        .dec_src_a_i   (dec_src_a),
        .dec_src_b_i   (dec_src_b),
        .dec_rs1_i     (dec_rs1),
        .dec_rs2_i     (dec_rs2),
        .dec_rd_i      (dec_rd),
        .dec_wr_reg_i  (dec_wr_reg),
        .dec_imm_i     (dec_imm),
        .res_valid_i   (res_valid),
        .res_tag_i     (res_tag),
        .res_data_i    (res_data),
        .commit_we_i   (commit_we_o),
        .commit_rd_i   (commit_rd_o),
        .commit_tag_i  (commit_tag),
        .commit_data_o (commit_data_o),
        .dp_valid_o    (dp_valid),
        .dp_op_o       (dp_op),
        .dp_src_a_o    (dp_src_a),
        .dp_src_b_o    (dp_src_b),
        .dp_op1_o      (dp_op1),
        .dp_op2_o      (dp_op2),
        .dp_pc_o       (dp_pc),
        .dp_imm_o      (dp_imm),
        .dp_tag_o      (dp_tag),
        .dp_rd_o       (dp_rd),
        .dp_wr_reg_o   (dp_wr_reg)
    );

    alu_unit u_alu_unit (
        .dp_valid_i    (dp_valid),
        .dp_op_i       (dp_op),
        .dp_src_a_i    (dp_src_a),
        .dp_src_b_i    (dp_src_b),
        .dp_op1_i      (dp_op1),
        .dp_op2_i      (dp_op2),
        .dp_pc_i       (dp_pc),
        .dp_imm_i      (dp_imm),
        .dp_tag_i      (dp_tag),
        .res_valid_o   (res_valid),
        .res_tag_o     (res_tag),
        .res_data_o    (res_data)
    );

    reorder_buffer u_reorder_buffer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dp_valid_i    (dp_valid),
        .dp_tag_i      (dp_tag),
        .dp_rd_i       (dp_rd),
        .dp_wr_reg_i   (dp_wr_reg),
        .res_valid_i   (res_valid),
        .res_tag_i     (res_tag),
        .commit_we_o   (commit_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_tag_o  (commit_tag)
    );

endmodule

// File: source/rename_unit.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module rename_unit (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   dec_valid_i,
    input  core_pkg::addr_t        dec_pc_i,
    input  core_pkg::alu_op_t      dec_op_i,
    input  core_pkg::src_a_sel_t   dec_src_a_i,
    input  core_pkg::src_b_sel_t   dec_src_b_i,
    input  core_pkg::reg_sel_t     dec_rs1_i,
    input  core_pkg::reg_sel_t     dec_rs2_i,
    input  core_pkg::reg_sel_t     dec_rd_i,
    input  logic                   dec_wr_reg_i,
    input  core_pkg::data_t        dec_imm_i,
    input  logic                   res_valid_i,
    input  core_pkg::rrf_tag_t     res_tag_i,
    input  core_pkg::data_t        res_data_i,
    input  logic                   commit_we_i,
    input  core_pkg::reg_sel_t     commit_rd_i,
    input  core_pkg::rrf_tag_t     commit_tag_i,
    output core_pkg::data_t        commit_data_o,
    output logic                   dp_valid_o,
    output core_pkg::alu_op_t      dp_op_o,
    output core_pkg::src_a_sel_t   dp_src_a_o,
    output core_pkg::src_b_sel_t   dp_src_b_o,
    output core_pkg::data_t        dp_op1_o,
    output core_pkg::data_t        dp_op2_o,
    output core_pkg::addr_t        dp_pc_o,
    output core_pkg::data_t        dp_imm_o,
    output core_pkg::rrf_tag_t     dp_tag_o,
    output core_pkg::reg_sel_t     dp_rd_o,
    output logic                   dp_wr_reg_o
);

    core_pkg::data_t    arf_data [`REG_NUM];
    core_pkg::rrf_tag_t arf_tag  [`REG_NUM];
    logic [`REG_NUM-1:0] arf_busy;
    core_pkg::data_t    rrf_data [`RRF_NUM];
    logic [`RRF_NUM-1:0] rrf_done;
    core_pkg::rrf_tag_t alloc_ptr;
    core_pkg::data_t    op1;
    core_pkg::data_t    op2;

    // x0, then ARF, then RRF, then the result bus
    function automatic core_pkg::data_t read_src(input core_pkg::reg_sel_t rs);
        core_pkg::rrf_tag_t tag;
        tag = arf_tag[rs];
        if (rs == '0)
            return '0;
        if (!arf_busy[rs])
            return arf_data[rs];
        if (rrf_done[tag])
            return rrf_data[tag];
        if (res_valid_i && res_tag_i == tag)
            return res_data_i;
        return rrf_data[tag];
    endfunction

    always_comb begin
        op1 = read_src(dec_rs1_i);
        op2 = read_src(dec_rs2_i);
    end

    assign commit_data_o = rrf_data[commit_tag_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            arf_busy   <= '0;
            rrf_done   <= '0;
            alloc_ptr  <= '0;
            dp_valid_o <= 1'b0;
            for (int i = 0; i < `REG_NUM; i++)
                arf_data[i] <= '0;
        end else begin
            dp_valid_o <= dec_valid_i;
            if (commit_we_i) begin
                arf_data[commit_rd_i] <= rrf_data[commit_tag_i];
                // a newer writer may own the register by now
                if (arf_tag[commit_rd_i] == commit_tag_i)
                    arf_busy[commit_rd_i] <= 1'b0;
            end
            if (dec_valid_i) begin
                alloc_ptr           <= alloc_ptr + 1'b1;
                rrf_done[alloc_ptr] <= 1'b0;
                if (dec_wr_reg_i)
                    arf_busy[dec_rd_i] <= 1'b1;
            end
            if (res_valid_i)
                rrf_done[res_tag_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_valid_i && dec_wr_reg_i)
            arf_tag[dec_rd_i] <= alloc_ptr;
        if (res_valid_i)
            rrf_data[res_tag_i] <= res_data_i;
        dp_op_o     <= dec_op_i;
        dp_src_a_o  <= dec_src_a_i;
        dp_src_b_o  <= dec_src_b_i;
        dp_op1_o    <= op1;
        dp_op2_o    <= op2;
        dp_pc_o     <= dec_pc_i;
        dp_imm_o    <= dec_imm_i;
        dp_tag_o    <= alloc_ptr;
        dp_rd_o     <= dec_rd_i;
        dp_wr_reg_o <= dec_wr_reg_i;
    end

endmodule

// File: source/reorder_buffer.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module reorder_buffer (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 dp_valid_i,
    input  core_pkg::rrf_tag_t   dp_tag_i,
    input  core_pkg::reg_sel_t   dp_rd_i,
    input  logic                 dp_wr_reg_i,
    input  logic                 res_valid_i,
    input  core_pkg::rrf_tag_t   res_tag_i,
    output logic                 commit_we_o,
    output core_pkg::reg_sel_t   commit_rd_o,
    output core_pkg::rrf_tag_t   commit_tag_o
);

    logic [`RRF_NUM-1:0] ent_valid;
    logic [`RRF_NUM-1:0] ent_done;
    logic [`RRF_NUM-1:0] ent_wr;
    core_pkg::reg_sel_t  ent_rd [`RRF_NUM];
    core_pkg::rrf_tag_t  head;
    logic                retire;

    assign retire       = ent_valid[head] && ent_done[head];
    // non-writing entries leave without a strobe
    assign commit_we_o  = retire && ent_wr[head];
    assign commit_rd_o  = ent_rd[head];
    assign commit_tag_o = head;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ent_valid <= '0;
            ent_done  <= '0;
            head      <= '0;
        end else begin
            if (retire) begin
                ent_valid[head] <= 1'b0;
                ent_done[head]  <= 1'b0;
                head            <= head + 1'b1;
            end
            if (dp_valid_i) begin
                ent_valid[dp_tag_i] <= 1'b1;
                ent_done[dp_tag_i]  <= 1'b0;
            end
            // result can land in the same cycle as dispatch
            if (res_valid_i)
                ent_done[res_tag_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dp_valid_i) begin
            ent_rd[dp_tag_i] <= dp_rd_i;
            ent_wr[dp_tag_i] <= dp_wr_reg_i;
        end
    end

endmodule

// File: tb.f
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/rename_unit.sv
source/alu_unit.sv
source/reorder_buffer.sv
source/helios_core.sv
verification/tb_helios_core.sv

// File: verification/tb_helios_core.sv
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_helios_core;

    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam int NUM_TESTS = 6;
    localparam int MEM_WORDS = 512;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    core_pkg::insn_t      idata_i = 32'h0000_0013;
    core_pkg::addr_t      iaddr_o;
    logic                 commit_we_o;
    core_pkg::reg_sel_t   commit_rd_o;
    core_pkg::data_t      commit_data_o;

    logic [31:0] imem [0:MEM_WORDS-1];
    int          prog_len = 0;
    logic        prog_ready = 1'b0;

    // model register file and expected commits in program order
    logic [31:0] ref_x [0:31];
    logic [4:0]  exp_rd [0:MEM_WORDS-1];
    logic [31:0] exp_data [0:MEM_WORDS-1];
    int          exp_idx [0:MEM_WORDS-1];
    int          exp_count = 0;
    int          rd_ptr = 0;
    int          test_end [0:NUM_TESTS-1];
    string       test_name [0:NUM_TESTS-1];
    int          test_errors [0:NUM_TESTS-1];
    int          cur_test = 0;
    int          error_count = 0;

    int          cyc = 0;
    logic        prev_rst = 1'b1;
    logic [31:0] prev_iaddr = '0;
    logic [31:0] fetched_addr = '0;
    logic        checks_on = 1'b0;
    logic [4:0]  head_rd;
    logic [31:0] head_data;
    int          head_idx;

    always #2 clk_i = ~clk_i;

    helios_core u_helios_core (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .idata_i       (idata_i),
        .iaddr_o       (iaddr_o),
        .commit_we_o   (commit_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - `ENTRY_POINT) >> 2;
        if (idx < 32'(prog_len))
            return imem[idx];
        return NOP;
    endfunction

    // synchronous memory, word shows up one cycle after its address
    always @(negedge clk_i) begin
        idata_i <= fetch_word(fetched_addr);
    end

    always @(posedge clk_i) begin
        if (rst_i)
            cyc <= 0;
        else
            cyc <= cyc + 1;
        prev_rst     <= rst_i;
        prev_iaddr   <= iaddr_o;
        fetched_addr <= iaddr_o;
        if (!rst_i && commit_we_o)
            rd_ptr <= rd_ptr + 1;
    end

    assign head_rd   = exp_rd[rd_ptr];
    assign head_data = exp_data[rd_ptr];
    assign head_idx  = exp_idx[rd_ptr];

    task automatic count_error();
        error_count++;
        test_errors[cur_test]++;
    endtask

    reset_quiet_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        cyc < 4 |-> !commit_we_o)
        else begin
            $display("error %0t: commit_we_o expected 0 got %b near reset",
                     $time, $sampled(commit_we_o));
            count_error();
        end

    fetch_start_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        !rst_i && prev_rst |-> iaddr_o == `ENTRY_POINT)
        else begin
            $display("error %0t: iaddr_o expected %h got %h",
                     $time, `ENTRY_POINT, $sampled(iaddr_o));
            count_error();
        end

    fetch_step_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        !rst_i && !prev_rst |-> iaddr_o == prev_iaddr + 32'd4)
        else begin
            $display("error %0t: iaddr_o expected %h got %h",
                     $time, $sampled(prev_iaddr) + 32'd4, $sampled(iaddr_o));
            count_error();
        end

    commit_expected_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        commit_we_o |-> rd_ptr < exp_count)
        else begin
            $display("%0t: commit to x%0d arrived after the model ran out of commits",
                     $time, $sampled(commit_rd_o));
            count_error();
        end

    commit_rd_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        commit_we_o && rd_ptr < exp_count |-> commit_rd_o == head_rd)
        else begin
            $display("error %0t: commit_rd_o expected %0d got %0d",
                     $time, $sampled(head_rd), $sampled(commit_rd_o));
            count_error();
        end

    commit_data_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        commit_we_o && rd_ptr < exp_count |-> commit_data_o == head_data)
        else begin
            $display("error %0t: commit_data_o expected %h got %h",
                     $time, $sampled(head_data), $sampled(commit_data_o));
            count_error();
        end

    // fetched in cycle k, committed in cycle k+4
    commit_cycle_check: assert property (@(posedge clk_i) disable iff (!checks_on)
        commit_we_o && rd_ptr < exp_count |-> cyc == head_idx + 4)
        else begin
            $display("error %0t: commit_we_o cycle expected %0d got %0d",
                     $time, $sampled(head_idx) + 4, $sampled(cyc));
            count_error();
        end

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OP_IMM};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // sel 0 to 7 by funct3, then SUB and SRA
    function automatic logic [31:0] r_op(input int sel, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
        if (sel < 8)
            return r_type(7'h00, 3'(sel), rd, rs1, rs2);
        return r_type(7'h20, (sel == 8) ? 3'b000 : 3'b101, rd, rs1, rs2);
    endfunction

    function automatic logic insn_legal(input logic [31:0] w);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = w[31:25];
        f3 = w[14:12];
        case (w[6:0])
            `OP_LUI, `OP_AUIPC: return 1'b1;
            `OP_IMM: begin
                if (f3 == 3'b001)
                    return f7 == 7'h00;
                if (f3 == 3'b101)
                    return f7 == 7'h00 || f7 == 7'h20;
                return 1'b1;
            end
            `OP_REG: return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] insn_value(input logic [31:0] w, input logic [31:0] pc,
                                               input logic [31:0] a, input logic [31:0] rb);
        logic [31:0] b;
        logic [4:0]  sh;
        logic        alt;
        if (w[6:0] == `OP_LUI)
            return {w[31:12], 12'h000};
        if (w[6:0] == `OP_AUIPC)
            return pc + {w[31:12], 12'h000};
        b   = (w[6:0] == `OP_IMM) ? {{20{w[31]}}, w[31:20]} : rb;
        sh  = b[4:0];
        alt = w[30];
        case (w[14:12])
            3'b000: return (w[6:0] == `OP_REG && alt) ? a - b : a + b;
            3'b001: return a << sh;
            3'b010: return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'b011: return {31'd0, a < b};
            3'b100: return a ^ b;
            // arithmetic shift fills the vacated top bits with the sign
            3'b101: return alt ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0))
                               : a >> sh;
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_insn(input logic [31:0] w, input logic [31:0] pc, input int idx);
        logic [31:0] value;
        logic [4:0]  rd;
        rd = w[11:7];
        if (!insn_legal(w) || rd == 5'd0)
            return;
        value = insn_value(w, pc, ref_x[w[19:15]], ref_x[w[24:20]]);
        ref_x[rd]           = value;
        exp_rd[exp_count]   = rd;
        exp_data[exp_count] = value;
        exp_idx[exp_count]  = idx;
        exp_count++;
    endtask

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        model_insn(w, `ENTRY_POINT + 32'(prog_len) * 32'd4, prog_len);
        prog_len++;
    endtask

    task automatic build_imm_test();
        emit(i_type(3'b000, 5'd1, 5'd0, 12'hffb));
        emit(i_type(3'b000, 5'd2, 5'd1, 12'h7ff));
        emit(i_type(3'b010, 5'd3, 5'd1, 12'hffc));
        emit(i_type(3'b010, 5'd4, 5'd2, 12'h001));
        emit(i_type(3'b011, 5'd5, 5'd1, 12'h003));
        emit(i_type(3'b011, 5'd6, 5'd0, 12'hfff));
        emit(i_type(3'b100, 5'd7, 5'd1, 12'h555));
        emit(i_type(3'b110, 5'd3, 5'd2, 12'h0f0));
        emit(i_type(3'b111, 5'd4, 5'd1, 12'h8ff));
        emit(i_type(3'b001, 5'd5, 5'd1, 12'h007));
        emit(i_type(3'b101, 5'd6, 5'd1, 12'h003));
        emit(i_type(3'b101, 5'd7, 5'd1, 12'h41f));
        emit(i_type(3'b101, 5'd3, 5'd2, 12'h404));
    endtask

    task automatic build_chain_test();
        logic [4:0] last;
        logic [4:0] prev;
        logic [4:0] rd;
        emit(i_type(3'b000, 5'd1, 5'd0, 12'h123));
        emit(u_type(`OP_LUI, 5'd2, 20'h87654));
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(r_type(7'h00, 3'b001, 5'd5, 5'd4, 5'd1));
        emit(r_type(7'h20, 3'b101, 5'd6, 5'd5, 5'd4));
        emit(r_type(7'h00, 3'b010, 5'd7, 5'd6, 5'd5));
        last = 5'd7;
        prev = 5'd6;
        // each op reads the last two results, one by bypass and one from the RRF
        for (int i = 0; i < 16; i++) begin
            rd = 5'(1 + $urandom % 7);
            emit(r_op(int'($urandom % 10), rd, last, prev));
            prev = last;
            last = rd;
        end
    endtask

    task automatic build_upper_test();
        emit(u_type(`OP_LUI, 5'd8, 20'hdead5));
        emit(u_type(`OP_AUIPC, 5'd9, 20'h00001));
        emit(u_type(`OP_AUIPC, 5'd10, 20'hfffff));
        emit(r_type(7'h00, 3'b000, 5'd11, 5'd8, 5'd9));
    endtask

    task automatic build_x0_test();
        emit(i_type(3'b000, 5'd0, 5'd1, 12'h005));
        emit(r_type(7'h00, 3'b000, 5'd12, 5'd0, 5'd0));
        emit(32'hffff_ffff);
        emit(r_type(7'h01, 3'b000, 5'd1, 5'd1, 5'd2));
        emit(i_type(3'b001, 5'd14, 5'd1, 12'h401));
        emit(r_type(7'h20, 3'b100, 5'd15, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b110, 5'd0, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b000, 5'd15, 5'd1, 5'd0));
        emit(i_type(3'b110, 5'd13, 5'd0, 12'h000));
    endtask

    task automatic build_random_test();
        int          kind;
        logic [31:0] w;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        for (int i = 0; i < 200; i++) begin
            kind = int'($urandom % 8);
            rd   = 5'($urandom % 8);
            rs1  = 5'($urandom % 8);
            rs2  = 5'($urandom % 8);
            f7   = ($urandom % 2 == 0) ? 7'h00 : 7'h20;
            if ($urandom % 8 == 0)
                f7 = 7'($urandom);
            case (kind)
                0:       w = i_type(3'($urandom), rd, rs1, 12'($urandom));
                1, 2:    w = i_type(3'($urandom), rd, rs1, {f7, 5'($urandom)});
                3, 4:    w = r_type(f7, 3'($urandom), rd, rs1, rs2);
                5:       w = u_type(`OP_LUI, rd, 20'($urandom));
                6:       w = u_type(`OP_AUIPC, rd, 20'($urandom));
                default: w = $urandom;
            endcase
            emit(w);
        end
    endtask

    initial begin
        int failed_tests;
        failed_tests = 0;
        rst_i = 1'b1;
        void'($urandom(32'h1dd5_271f));
        for (int r = 0; r < 32; r++)
            ref_x[r] = '0;
        for (int k = 0; k < NUM_TESTS; k++)
            test_errors[k] = 0;
        test_name[0] = "reset and fetch";
        test_name[1] = "register-immediate ops";
        test_name[2] = "register-register chains";
        test_name[3] = "lui and auipc";
        test_name[4] = "illegal words and x0";
        test_name[5] = "random program";
        test_end[0] = 0;
        build_imm_test();
        test_end[1] = exp_count;
        build_chain_test();
        test_end[2] = exp_count;
        build_upper_test();
        test_end[3] = exp_count;
        build_x0_test();
        test_end[4] = exp_count;
        build_random_test();
        test_end[5] = exp_count;
        prog_ready = 1'b1;

        @(negedge clk_i);
        checks_on = 1'b1;
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;

        for (int k = 0; k < NUM_TESTS; k++) begin
            cur_test = k;
            while (rd_ptr < test_end[k] || cyc < 5)
                @(negedge clk_i);
            // extra commits after the last one would show up here
            if (k == NUM_TESTS - 1)
                repeat (16) @(negedge clk_i);
            if (test_errors[k] != 0)
                failed_tests++;
            $display("test %0d (%s): %0d commits, %0d errors, %s", k, test_name[k],
                     test_end[k] - ((k == 0) ? 0 : test_end[k-1]), test_errors[k],
                     (test_errors[k] == 0) ? "ok" : "failed");
        end

        $display("done: %0d tests, %0d failed, %0d commits checked, %0d errors",
                 NUM_TESTS, failed_tests, rd_ptr, error_count);
        if (error_count == 0 && failed_tests == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    initial begin
        wait (prog_ready);
        #((prog_len + 50) * 4);
        $display("watchdog: run still going at %0t, %0d of %0d commits seen",
                 $time, rd_ptr, exp_count);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
